/* rtl/gcn_macros.svh */
`ifndef GCN_MACROS_SVH
`define GCN_MACROS_SVH

// Feature elements handled per chunk (one PE)
`define MULT_PER_PE 4

// Longest feature vector held in the feature buffer
`define MAX_FV_NUM 32

// Most weight layers held in the weight buffer
`define MAX_NUM_WEIGHT_LAYER 4

// Datapath widths
`define FEATURE_W 8
`define ACC_W 16

// Write address covers the larger of the two scratch memories
`define WR_ADDR_W $clog2(`MAX_FV_NUM * `MAX_NUM_WEIGHT_LAYER)

`endif

/* rtl/gcn_pkg.sv */
`include "gcn_macros.svh"

package gcn_pkg;

    // Ternary code: 0 zero, 1 plus one, 2 minus one, 3 zero
    typedef logic [1:0] weight_t;

    typedef logic signed [`FEATURE_W-1:0] feature_t;

    typedef logic signed [`ACC_W-1:0] acc_t;

    typedef logic [$clog2(`MAX_NUM_WEIGHT_LAYER)-1:0] layer_idx_t;

    // One bit wider so that a full-length vector count fits
    typedef logic [$clog2(`MAX_FV_NUM):0] fv_idx_t;

    // One chunk read request, with the stream markers
    typedef struct packed {
        logic       valid;
        layer_idx_t layer;
        fv_idx_t    fv_base;
        logic       sos;     // first chunk of the run
        logic       change;  // last chunk of a layer
        logic       eos;     // last chunk of the run
    } chunk_issue_t;

    // Finished dot product for one layer
    typedef struct packed {
        logic       valid;
        layer_idx_t layer;
        acc_t       value;
        logic       eos;
    } layer_result_t;

endpackage

/* rtl/lane_buffer.sv */
`include "gcn_macros.svh"

module lane_buffer #(
    parameter type word_t = logic,
    parameter int DEPTH = `MAX_FV_NUM
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic [`WR_ADDR_W-1:0]         wr_addr,
    input  word_t                         wr_data,
    input  gcn_pkg::chunk_issue_t         issue,
    output word_t [`MULT_PER_PE-1:0]      lanes,
    output gcn_pkg::chunk_issue_t         issue_q
);
    import gcn_pkg::*;

    localparam int AW = $clog2(DEPTH);

    word_t mem [DEPTH];

    logic [`WR_ADDR_W-1:0] full_addr;
    logic [AW-1:0]         rd_addr;

    // Layer-major address; the feature buffer keeps only the fv_base bits
    assign full_addr = {issue.layer, issue.fv_base[$clog2(`MAX_FV_NUM)-1:0]};
    assign rd_addr   = full_addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[AW-1:0]] <= wr_data;
        end
    end

    // Chunk never crosses a row since num_fv is a multiple of MULT_PER_PE
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MULT_PER_PE; i++) begin
            lanes[i] <= mem[rd_addr + AW'(i)];
        end
    end

    // Markers travel alongside the lane data
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_q <= '0;
        end else begin
            issue_q <= issue;
        end
    end

    a_wr_in_range: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (wr_addr < DEPTH));

    // Host writes must not overlap a run
    a_no_wr_in_run: assert property (@(posedge clk) disable iff (reset)
        issue.valid |-> !wr_en);

endmodule

/* rtl/weight_ctrl.sv */
`include "gcn_macros.svh"

module weight_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fire,
    input  gcn_pkg::layer_idx_t    num_layer_m1,
    input  gcn_pkg::fv_idx_t       num_fv,
    output gcn_pkg::chunk_issue_t  issue,
    output logic                   idle
);
    import gcn_pkg::*;

    typedef enum logic {
        IDLE,
        WORK
    } state_t;

    state_t     state;
    layer_idx_t layer;
    fv_idx_t    fv_base;
    fv_idx_t    fv_next;

    // Run shape, captured when fire is accepted
    layer_idx_t num_layer_q;
    fv_idx_t    num_fv_q;

    logic last_chunk;
    logic last_layer;

    assign fv_next    = fv_base + fv_idx_t'(`MULT_PER_PE);
    assign last_chunk = (fv_next == num_fv_q);
    assign last_layer = (layer == num_layer_q);

    // One chunk request per WORK cycle
    always_comb begin
        issue = '0;
        if (state == WORK) begin
            issue.valid   = 1'b1;
            issue.layer   = layer;
            issue.fv_base = fv_base;
            issue.sos     = (layer == '0) && (fv_base == '0);
            issue.change  = last_chunk;
            issue.eos     = last_chunk && last_layer;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && fire) begin
            num_layer_q <= num_layer_m1;
            num_fv_q    <= num_fv;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            layer   <= '0;
            fv_base <= '0;
            idle    <= 1'b0;
        end else begin
            idle <= (state == IDLE) && !fire;
            case (state)
                IDLE: begin
                    if (fire) begin
                        state   <= WORK;
                        layer   <= '0;
                        fv_base <= '0;
                    end
                end
                WORK: begin
                    if (last_chunk) begin
                        fv_base <= '0;
                        if (last_layer) begin
                            state <= IDLE;
                            layer <= '0;
                        end else begin
                            layer <= layer + 1'b1;
                        end
                    end else begin
                        fv_base <= fv_next;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_fv_shape: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE && fire) |->
            (num_fv != '0 && (num_fv % `MULT_PER_PE) == 0));

endmodule

/* rtl/vertex_mac.sv */
`include "gcn_macros.svh"

module vertex_mac (
    input  logic                                   clk,
    input  logic                                   reset,
    input  gcn_pkg::weight_t [`MULT_PER_PE-1:0]    weight_lanes,
    input  gcn_pkg::feature_t [`MULT_PER_PE-1:0]   feature_lanes,
    input  gcn_pkg::chunk_issue_t                  issue_q,
    output gcn_pkg::layer_result_t                 result
);
    import gcn_pkg::*;

    acc_t lane_sum;
    acc_t acc;          // sum of earlier chunks in this layer
    acc_t chunk_total;

    // Ternary multiply folded into an add, subtract or skip
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `MULT_PER_PE; i++) begin
            case (weight_lanes[i])
                2'd1: lane_sum = lane_sum + acc_t'(feature_lanes[i]);
                2'd2: lane_sum = lane_sum - acc_t'(feature_lanes[i]);
                default: lane_sum = lane_sum;
            endcase
        end
    end

    // First chunk of a run never picks up a stale sum
    assign chunk_total = (issue_q.sos ? acc_t'(0) : acc) + lane_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc    <= '0;
            result <= '0;
        end else begin
            result <= '0;
            if (issue_q.valid) begin
                // Restart after each finished layer
                acc <= issue_q.change ? acc_t'(0) : chunk_total;
                if (issue_q.change) begin
                    result.valid <= 1'b1;
                    result.layer <= issue_q.layer;
                    result.value <= chunk_total;
                    result.eos   <= issue_q.eos;
                end
            end
        end
    end

    a_eos_on_change: assert property (@(posedge clk) disable iff (reset)
        (issue_q.valid && issue_q.eos) |-> issue_q.change);

endmodule

/* rtl/result_bank.sv */
`include "gcn_macros.svh"

module result_bank (
    input  logic                    clk,
    input  logic                    reset,
    input  gcn_pkg::layer_result_t  result,
    input  gcn_pkg::layer_idx_t     rd_layer,
    output gcn_pkg::acc_t           rd_result,
    output logic                    done
);
    import gcn_pkg::*;

    // One entry per weight layer
    acc_t bank [`MAX_NUM_WEIGHT_LAYER];

    always_ff @(posedge clk) begin
        if (result.valid) begin
            bank[result.layer] <= result.value;
        end
    end

    // Registered read port for the host
    always_ff @(posedge clk) begin
        rd_result <= bank[rd_layer];
    end

    // Single-cycle pulse as the last layer lands
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= result.valid && result.eos;
        end
    end

endmodule

/* rtl/gcn_weight_top.sv */
`include "gcn_macros.svh"

module gcn_weight_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fire,
    input  gcn_pkg::layer_idx_t     num_layer_m1,
    input  gcn_pkg::fv_idx_t        num_fv,
    input  logic                    wr_weight_en,
    input  logic                    wr_feature_en,
    input  logic [`WR_ADDR_W-1:0]   wr_addr,
    input  logic [`FEATURE_W-1:0]   wr_data,
    input  gcn_pkg::layer_idx_t     rd_layer,
    output gcn_pkg::acc_t           rd_result,
    output logic                    idle,
    output logic                    done
);
    import gcn_pkg::*;

    chunk_issue_t                   issue;
    chunk_issue_t                   issue_q;
    weight_t [`MULT_PER_PE-1:0]     weight_lanes;
    feature_t [`MULT_PER_PE-1:0]    feature_lanes;
    layer_result_t                  result;

    weight_ctrl u_weight_ctrl (
        .clk          (clk),
        .reset        (reset),
        .fire         (fire),
        .num_layer_m1 (num_layer_m1),
        .num_fv       (num_fv),
        .issue        (issue),
        .idle         (idle)
    );

    // Weight rows laid out layer by layer
    lane_buffer #(
        .word_t (weight_t),
        .DEPTH  (`MAX_FV_NUM * `MAX_NUM_WEIGHT_LAYER)
    ) u_weight_buf (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_weight_en),
        .wr_addr (wr_addr),
        .wr_data (weight_t'(wr_data[1:0])),
        .issue   (issue),
        .lanes   (weight_lanes),
        .issue_q (issue_q)
    );

    // Markers come from the weight side; both buffers share one timing
    lane_buffer #(
        .word_t (feature_t),
        .DEPTH  (`MAX_FV_NUM)
    ) u_feature_buf (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_feature_en),
        .wr_addr (wr_addr),
        .wr_data (feature_t'(wr_data)),
        .issue   (issue),
        .lanes   (feature_lanes),
        .issue_q ()
    );

    vertex_mac u_vertex_mac (
        .clk           (clk),
        .reset         (reset),
        .weight_lanes  (weight_lanes),
        .feature_lanes (feature_lanes),
        .issue_q       (issue_q),
        .result        (result)
    );

    result_bank u_result_bank (
        .clk       (clk),
        .reset     (reset),
        .result    (result),
        .rd_layer  (rd_layer),
        .rd_result (rd_result),
        .done      (done)
    );

endmodule

/* test/clk_gen.sv */
module clk_gen #(
    parameter int PERIOD = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* test/tb_gcn_weight.sv */
`include "gcn_macros.svh"

module tb_gcn_weight;
    import gcn_pkg::*;

    localparam int MAX_CYCLES = 400;

    logic                  clk;
    logic                  reset;
    logic                  fire;
    layer_idx_t            num_layer_m1;
    fv_idx_t               num_fv;
    logic                  wr_weight_en;
    logic                  wr_feature_en;
    logic [`WR_ADDR_W-1:0] wr_addr;
    logic [`FEATURE_W-1:0] wr_data;
    layer_idx_t            rd_layer;
    acc_t                  rd_result;
    logic                  idle;
    logic                  done;

    // Reference copies of both scratch memories and the expected results
    int weight_model [`MAX_FV_NUM * `MAX_NUM_WEIGHT_LAYER];
    int feature_model [`MAX_FV_NUM];
    int layer_model [`MAX_NUM_WEIGHT_LAYER];
    bit layer_known [`MAX_NUM_WEIGHT_LAYER];

    int          value_errors;
    int          other_errors;
    logic [31:0] lcg_state = 32'h7636;

    clk_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    gcn_weight_top i_gcn_weight_top (.*);

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state >> 16);
    endfunction

    // Code 1 adds the feature, 2 subtracts it, 0 and 3 add nothing
    function automatic int ternary_term(input int code, input int feat);
        case (code)
            1: return feat;
            2: return -feat;
            default: return 0;
        endcase
    endfunction

    task automatic write_word(input bit is_weight, input int addr, input int value);
        @(negedge clk);
        wr_addr       = addr;
        wr_data       = value[7:0];
        wr_weight_en  = is_weight;
        wr_feature_en = !is_weight;
        @(negedge clk);
        wr_weight_en  = 1'b0;
        wr_feature_en = 1'b0;
        if (is_weight) begin
            weight_model[addr] = value & 3;
        end else begin
            feature_model[addr] = $signed(value[7:0]);
        end
    endtask

    task automatic check_layer(input int layer, input int expected);
        acc_t got;
        @(negedge clk);
        rd_layer = layer_idx_t'(layer);
        @(negedge clk);
        got = rd_result;
        if (got !== acc_t'(expected)) begin
            value_errors++;
            $display("ERR %0t: layer %0d result %0d, expected %0d", $time, layer, got, expected);
        end
    endtask

    // Fire one run; optionally pulse fire again refire_at cycles in
    task automatic run(input int layers, input int fv, input int refire_at);
        int  cycles;
        int  low_cycles;
        int  dones;
        int  sum;
        bit  finished;
        cycles     = 0;
        low_cycles = 0;
        dones      = 0;
        finished   = 1'b0;
        @(negedge clk);
        num_layer_m1 = layer_idx_t'(layers - 1);
        num_fv       = fv_idx_t'(fv);
        fire         = 1'b1;
        while (!finished && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
            fire = (cycles == refire_at);
            if (!idle) low_cycles++;
            if (done) dones++;
            finished = (dones > 0) && idle;
        end
        fire = 1'b0;
        if (!finished) begin
            other_errors++;
            $display("Timeout: run of %0d layers did not finish in %0d cycles", layers, cycles);
        end
        // Short window to catch a second done pulse
        repeat (3) begin
            @(negedge clk);
            if (done) dones++;
        end
        if (dones != 1) begin
            value_errors++;
            $display("ERR %0t: %0d done pulses in one run, expected 1", $time, dones);
        end
        // Idle drops with the accepted fire and rises one cycle after WORK
        if (low_cycles != layers * fv / `MULT_PER_PE + 1) begin
            value_errors++;
            $display("ERR %0t: idle low for %0d cycles, expected %0d", $time, low_cycles,
                     layers * fv / `MULT_PER_PE + 1);
        end
        for (int l = 0; l < layers; l++) begin
            sum = 0;
            for (int i = 0; i < fv; i++) begin
                sum += ternary_term(weight_model[l * `MAX_FV_NUM + i], feature_model[i]);
            end
            layer_model[l] = sum;
            layer_known[l] = 1'b1;
        end
    endtask

    initial begin
        string       line;
        int          fd;
        int          a;
        int          b;
        int          c;
        int          n;
        int          cycles;
        logic [7:0]  cmd;
        fire          = 1'b0;
        num_layer_m1  = '0;
        num_fv        = '0;
        wr_weight_en  = 1'b0;
        wr_feature_en = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        rd_layer      = '0;
        value_errors  = 0;
        other_errors  = 0;

        cycles = 0;
        while (idle !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
            if (done !== 1'b0) begin
                value_errors++;
                $display("ERR %0t: done pulsed before any fire", $time);
            end
        end
        if (idle !== 1'b1) begin
            other_errors++;
            $display("Timeout: idle did not rise after reset");
        end

        fd = $fopen("test/gcn_weight_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the test file test/gcn_weight_tests.txt");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                c = 0;
                n = $sscanf(line, "%c %d %d %d", cmd, a, b, c);
                case (cmd)
                    "W": write_word(1'b1, a, b);
                    "F": write_word(1'b0, a, b);
                    "L": for (int i = 0; i < b; i++) write_word(1'b1, a + i, lcg_next());
                    "G": for (int i = 0; i < b; i++) write_word(1'b0, a + i, lcg_next());
                    "R": run(a, b, c);
                    "E": check_layer(a, b);
                    "C": begin
                        for (int l = 0; l < `MAX_NUM_WEIGHT_LAYER; l++) begin
                            if (layer_known[l]) check_layer(l, layer_model[l]);
                        end
                    end
                    default: begin
                        other_errors++;
                        $display("Unknown command in test file (%0d fields): %s", n, line);
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Error counts: %0d wrong values, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* gcn_weight.f */
+incdir+rtl
rtl/gcn_pkg.sv
rtl/lane_buffer.sv
rtl/weight_ctrl.sv
rtl/vertex_mac.sv
rtl/result_bank.sv
rtl/gcn_weight_top.sv
test/clk_gen.sv
test/tb_gcn_weight.sv

/* Bender.yml */
package:
  name: gcn_weight

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/gcn_pkg.sv
      - rtl/lane_buffer.sv
      - rtl/weight_ctrl.sv
      - rtl/vertex_mac.sv
      - rtl/result_bank.sv
      - rtl/gcn_weight_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/clk_gen.sv
      - test/tb_gcn_weight.sv

/* test/gcn_weight_tests.txt */
# Columns: command then decimal fields. W/F addr value write a weight/feature word
# L/G addr count fill weights/features from the LCG, R layers fv [refire], E layer value, C
W 0 1
W 1 2
W 2 3
W 3 0
W 4 1
W 5 1
W 6 2
W 7 2
F 0 10
F 1 -5
F 2 7
F 3 100
F 4 -20
F 5 3
F 6 -8
F 7 50
R 1 8
E 0 -44
L 0 128
G 0 32
R 4 32
C
R 4 32 3
C
R 4 16
C
